//--- hw/stepper_pkg.sv
package stepper_pkg;

  // Phase counts per electrical cycle and the coil offsets
  localparam int PHASE_STEPS = 192;
  localparam int COIL_B_OFFSET = 64;
  localparam int COIL_C_OFFSET = 128;

  typedef logic [7:0] phase_t;
  typedef logic [9:0] off_time_t;
  typedef logic [7:0] short_time_t;

  // Per coil {s_1, s_2}, s_1 set drives leg 1 high
  typedef struct packed {
    logic [1:0] a;
    logic [1:0] b;
    logic [1:0] c;
  } polarity_t;

  typedef struct packed {
    short_time_t blank;
    off_time_t   off;
    short_time_t min_on;
  } coil_timers_t;

  typedef struct packed {
    off_time_t fastdecay_threshold;
    logic      invert_high;
    logic      invert_low;
  } bridge_cfg_t;

  // Leg order from MSB: a1, a2, b1, b2, c1, c2
  typedef struct packed {
    logic [5:0] high;
    logic [5:0] low;
  } gates_t;

endpackage

//--- hw/step_decode.sv
`timescale 1ns/1ps

module step_decode import stepper_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  logic      step,
  input  logic      dir,
  input  logic      enable_in,
  output phase_t    phase_a,
  output phase_t    phase_b,
  output phase_t    phase_c,
  output polarity_t polarity,
  output logic      enable
);

  logic [1:0] step_sync;
  logic [1:0] dir_sync;
  logic       step_prev;
  logic       step_rise;
  phase_t     count [3];

  // Wrapping step of one phase counter
  function automatic phase_t next_phase(phase_t p, logic up);
    if (up) begin
      return (p == phase_t'(PHASE_STEPS - 1)) ? '0 : phase_t'(p + 1'b1);
    end
    return (p == '0) ? phase_t'(PHASE_STEPS - 1) : phase_t'(p - 1'b1);
  endfunction

  // First half of the cycle drives leg 1 high, second half leg 2
  function automatic logic [1:0] polarity_of(phase_t p);
    return (p < phase_t'(PHASE_STEPS / 2)) ? 2'b10 : 2'b01;
  endfunction

  // Two flop synchronizers plus edge detect on step
  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_sync <= '0;
      dir_sync  <= '0;
      step_prev <= 1'b0;
      enable    <= 1'b0;
    end else begin
      step_sync <= {step_sync[0], step};
      dir_sync  <= {dir_sync[0], dir};
      step_prev <= step_sync[1];
      enable    <= enable_in;
    end
  end

  assign step_rise = step_sync[1] & ~step_prev;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count[0] <= '0;
      count[1] <= phase_t'(COIL_B_OFFSET);
      count[2] <= phase_t'(COIL_C_OFFSET);
    end else if (step_rise) begin
      for (int i = 0; i < 3; i++) begin
        count[i] <= next_phase(count[i], dir_sync[1]);
      end
    end
  end

  assign phase_a = count[0];
  assign phase_b = count[1];
  assign phase_c = count[2];

  assign polarity.a = polarity_of(count[0]);
  assign polarity.b = polarity_of(count[1]);
  assign polarity.c = polarity_of(count[2]);

endmodule

//--- hw/chopper_timers.sv
`timescale 1ns/1ps

module chopper_timers import stepper_pkg::*; #(
  parameter int OFF_TIME    = 40,
  parameter int BLANK_TIME  = 6,
  parameter int MIN_ON_TIME = 12
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic         [2:0] off_start,
  output coil_timers_t [2:0] timers
);

  localparam off_time_t   OFF_LOAD    = off_time_t'(OFF_TIME);
  localparam short_time_t BLANK_LOAD  = short_time_t'(BLANK_TIME);
  localparam short_time_t MIN_ON_LOAD = short_time_t'(MIN_ON_TIME);

  logic [2:0] off_done;

  // Last off count, a new on period begins on this edge
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      off_done[i] = (timers[i].off == off_time_t'(1));
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < 3; i++) begin
        timers[i].off    <= '0;
        timers[i].blank  <= BLANK_LOAD;
        timers[i].min_on <= MIN_ON_LOAD;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        // Off timer, loaded by the comparator trip
        if (off_start[i]) begin
          timers[i].off <= OFF_LOAD;
        end else if (timers[i].off != '0) begin
          timers[i].off <= timers[i].off - 1'b1;
        end

        // Blanking hides the switching spike at the start of the on period
        if (off_done[i]) begin
          timers[i].blank <= BLANK_LOAD;
        end else if (timers[i].blank != '0) begin
          timers[i].blank <= timers[i].blank - 1'b1;
        end

        // Minimum on window, a trip inside it is a fault
        if (off_done[i]) begin
          timers[i].min_on <= MIN_ON_LOAD;
        end else if (timers[i].min_on != '0) begin
          timers[i].min_on <= timers[i].min_on - 1'b1;
        end
      end
    end
  end

endmodule

//--- hw/bridge_control.sv
`timescale 1ns/1ps

module bridge_control import stepper_pkg::*; (
  input  logic               clk,
  input  logic               resetn,
  input  bridge_cfg_t        cfg,
  input  polarity_t          polarity,
  input  logic               enable,
  input  coil_timers_t [2:0] timers,
  input  logic         [2:0] analog_cmp,
  output gates_t             gates,
  output logic               faultn,
  output logic         [2:0] off_start
);

  logic [2:0][1:0] pol;
  logic [2:0]      fast_decay;
  logic [2:0]      slow_decay;
  logic [2:0]      coil_fault;
  logic [5:0]      raw_high;
  logic [5:0]      raw_low;
  // Gate controls before inversion, in gates_t leg order
  logic [5:0]      high_ctrl;
  logic [5:0]      low_ctrl;

  assign pol[0] = polarity.a;
  assign pol[1] = polarity.b;
  assign pol[2] = polarity.c;

  // Decay mode per coil, fast for the first part of the off time
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      fast_decay[i] = (timers[i].off != '0) &&
                      (timers[i].off >= cfg.fastdecay_threshold);
      slow_decay[i] = (timers[i].off != '0) && !fast_decay[i];
    end
  end

  // Fast decay swaps the legs, slow decay shorts through both low sides
  always_comb begin
    int  leg;
    logic s;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 2; j++) begin
        leg = 5 - 2 * i - j;
        s = pol[i][1 - j];
        raw_high[leg] = !slow_decay[i] && (fast_decay[i] ? !s : s);
        raw_low[leg]  = slow_decay[i] || (fast_decay[i] ? s : !s);
      end
    end
  end

  // Disabled bridge parks on the low sides, fault only drops high sides
  assign low_ctrl  = raw_low | {6{~enable}};
  assign high_ctrl = raw_high & {6{faultn & enable}};

  assign gates.high = high_ctrl ^ {6{cfg.invert_high}};
  assign gates.low  = low_ctrl ^ {6{cfg.invert_low}};

  // Peak current reached outside blanking starts the off time
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      off_start[i] = analog_cmp[i] && (timers[i].blank == '0) &&
                     (timers[i].off == '0);
    end
  end

  // Off time running while minimum on is still counting
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      coil_fault[i] = (timers[i].off != '0) && (timers[i].min_on != '0);
    end
  end

  // Latched until reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if (|coil_fault) begin
      faultn <= 1'b0;
    end
  end

endmodule

//--- hw/microstepper_top.sv
`timescale 1ns/1ps

module microstepper_top import stepper_pkg::*; #(
  parameter int OFF_TIME    = 40,
  parameter int BLANK_TIME  = 6,
  parameter int MIN_ON_TIME = 12
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        step,
  input  logic        dir,
  input  logic        enable_in,
  input  logic  [2:0] analog_cmp,
  input  bridge_cfg_t cfg,
  output gates_t      gates,
  output logic        faultn,
  output phase_t      phase_a,
  output phase_t      phase_b,
  output phase_t      phase_c
);

  polarity_t          polarity;
  logic               enable;
  coil_timers_t [2:0] timers;
  logic         [2:0] off_start;

  step_decode u_step_decode (
    .clk       (clk),
    .resetn    (resetn),
    .step      (step),
    .dir       (dir),
    .enable_in (enable_in),
    .phase_a   (phase_a),
    .phase_b   (phase_b),
    .phase_c   (phase_c),
    .polarity  (polarity),
    .enable    (enable)
  );

  chopper_timers #(
    .OFF_TIME    (OFF_TIME),
    .BLANK_TIME  (BLANK_TIME),
    .MIN_ON_TIME (MIN_ON_TIME)
  ) u_chopper_timers (
    .clk       (clk),
    .resetn    (resetn),
    .off_start (off_start),
    .timers    (timers)
  );

  bridge_control u_bridge_control (
    .clk        (clk),
    .resetn     (resetn),
    .cfg        (cfg),
    .polarity   (polarity),
    .enable     (enable),
    .timers     (timers),
    .analog_cmp (analog_cmp),
    .gates      (gates),
    .faultn     (faultn),
    .off_start  (off_start)
  );

endmodule

//--- test/bridge_chk.sv
`timescale 1ns/1ps

module bridge_chk import stepper_pkg::*; (
  input logic               clk,
  input logic               resetn,
  input logic         [5:0] high_ctrl,
  input logic         [5:0] low_ctrl,
  input logic               faultn,
  input logic         [2:0] off_start,
  input coil_timers_t [2:0] timers
);

  logic [2:0] coil_idle;
  logic [2:0] off_busy;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      coil_idle[i] = (timers[i].blank == '0) && (timers[i].off == '0);
      off_busy[i]  = (timers[i].off != '0);
    end
  end

  // No leg conducts through both of its switches
  a_no_shoot_through: assert property (@(posedge clk) disable iff (!resetn)
    (high_ctrl & low_ctrl) == 6'b0)
    else $error("high and low control of one leg on together");

  // Once tripped the latch holds until reset
  a_fault_held: assert property (@(posedge clk) (resetn && !faultn) |=> !faultn)
    else $error("faultn released without reset");

  // An off period begins exactly one edge after off_start on an idle coil
  a_off_start_idle: assert property (@(posedge clk) disable iff (!resetn)
    $past(off_start) == (off_busy & ~$past(off_busy) & $past(coil_idle)))
    else $error("off_start fired outside an idle coil or did not start the off time");

endmodule

//--- test/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import stepper_pkg::*; #(
  parameter int OFF_TIME    = 40,
  parameter int BLANK_TIME  = 6,
  parameter int MIN_ON_TIME = 12
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        step,
  input  logic        dir,
  input  logic        enable_in,
  input  logic  [2:0] analog_cmp,
  input  bridge_cfg_t cfg,
  input  gates_t      gates,
  input  logic        faultn,
  input  phase_t      phase_a,
  input  phase_t      phase_b,
  input  phase_t      phase_c,
  output int          checks,
  output int          errors
);

  logic [1:0]  m_step_sync;
  logic [1:0]  m_dir_sync;
  logic        m_step_prev;
  logic        m_en;
  logic        m_faultn;
  logic        started;
  phase_t      m_cnt [3];
  off_time_t   m_off [3];
  short_time_t m_blank [3];
  short_time_t m_min_on [3];

  initial begin
    checks  = 0;
    errors  = 0;
    started = 1'b0;
  end

  // Expected gates from counts, off timers, enable, fault latch and cfg
  function automatic gates_t expected_gates(logic [2:0][7:0] cnt, logic [2:0][9:0] off,
                                            logic en, logic fn, bridge_cfg_t c);
    gates_t g;
    logic   s1;
    logic   s;
    logic   fast;
    logic   slow;
    logic   hi;
    logic   lo;
    int     leg;
    for (int i = 0; i < 3; i++) begin
      s1   = cnt[i] < 8'd96;
      fast = (off[i] != 10'd0) && (off[i] >= c.fastdecay_threshold);
      slow = (off[i] != 10'd0) && !fast;
      for (int j = 0; j < 2; j++) begin
        s   = (j == 0) ? s1 : !s1;
        leg = 5 - 2 * i - j;
        hi  = !slow && (fast ? !s : s);
        lo  = slow || (fast ? s : !s);
        if (!en) begin
          hi = 1'b0;
          lo = 1'b1;
        end
        if (!fn) hi = 1'b0;
        g.high[leg] = hi ^ c.invert_high;
        g.low[leg]  = lo ^ c.invert_low;
      end
    end
    return g;
  endfunction

  task automatic check_value(string name, logic [11:0] exp, logic [11:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("Fail %s exp %h got %h", name, exp, got);
    end
  endtask

  // Reference state, advanced on the same edges as the DUT
  always @(posedge clk) begin : model_update
    logic rise;
    logic up;
    logic fault_now;
    logic trip;
    logic done;
    started = 1'b1;
    if (!resetn) begin
      m_step_sync = 2'b00;
      m_dir_sync  = 2'b00;
      m_step_prev = 1'b0;
      m_en        = 1'b0;
      m_faultn    = 1'b1;
      m_cnt[0]    = 8'd0;
      m_cnt[1]    = 8'd64;
      m_cnt[2]    = 8'd128;
      for (int i = 0; i < 3; i++) begin
        m_off[i]    = 10'd0;
        m_blank[i]  = short_time_t'(BLANK_TIME);
        m_min_on[i] = short_time_t'(MIN_ON_TIME);
      end
    end else begin
      rise      = m_step_sync[1] & ~m_step_prev;
      up        = m_dir_sync[1];
      fault_now = 1'b0;
      for (int i = 0; i < 3; i++) begin
        fault_now = fault_now | ((m_off[i] != 10'd0) && (m_min_on[i] != 8'd0));
        trip = analog_cmp[i] && (m_blank[i] == 8'd0) && (m_off[i] == 10'd0);
        done = (m_off[i] == 10'd1);
        if (trip) m_off[i] = off_time_t'(OFF_TIME);
        else if (m_off[i] != 10'd0) m_off[i] = m_off[i] - 1'b1;
        if (done) m_blank[i] = short_time_t'(BLANK_TIME);
        else if (m_blank[i] != 8'd0) m_blank[i] = m_blank[i] - 1'b1;
        if (done) m_min_on[i] = short_time_t'(MIN_ON_TIME);
        else if (m_min_on[i] != 8'd0) m_min_on[i] = m_min_on[i] - 1'b1;
        if (rise && up) m_cnt[i] = (m_cnt[i] == 8'd191) ? 8'd0 : m_cnt[i] + 1'b1;
        if (rise && !up) m_cnt[i] = (m_cnt[i] == 8'd0) ? 8'd191 : m_cnt[i] - 1'b1;
      end
      if (fault_now) m_faultn = 1'b0;
      m_step_prev = m_step_sync[1];
      m_step_sync = {m_step_sync[0], step};
      m_dir_sync  = {m_dir_sync[0], dir};
      m_en        = enable_in;
    end
  end

  // Outputs are settled mid cycle
  always @(negedge clk) begin : compare
    gates_t exp;
    if (started) begin
      exp = expected_gates({m_cnt[2], m_cnt[1], m_cnt[0]}, {m_off[2], m_off[1], m_off[0]},
                           m_en, m_faultn, cfg);
      check_value("gates", exp, gates);
      check_value("faultn", {11'b0, m_faultn}, {11'b0, faultn});
      check_value("phase_a", {4'b0, m_cnt[0]}, {4'b0, phase_a});
      check_value("phase_b", {4'b0, m_cnt[1]}, {4'b0, phase_b});
      check_value("phase_c", {4'b0, m_cnt[2]}, {4'b0, phase_c});
    end
  end

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ps

module tb_top import stepper_pkg::*; ();

  localparam int OFF_TIME    = 40;
  localparam int BLANK_TIME  = 6;
  localparam int MIN_ON_TIME = 12;

  logic        clk;
  logic        resetn;
  logic        step;
  logic        dir;
  logic        enable_in;
  logic  [2:0] analog_cmp;
  bridge_cfg_t cfg;
  gates_t      gates;
  logic        faultn;
  phase_t      phase_a;
  phase_t      phase_b;
  phase_t      phase_c;
  logic [31:0] rnd;
  int          checks;
  int          errors;
  int          timeouts;

  microstepper_top #(
    .OFF_TIME    (OFF_TIME),
    .BLANK_TIME  (BLANK_TIME),
    .MIN_ON_TIME (MIN_ON_TIME)
  ) dut0 (
    .clk        (clk),
    .resetn     (resetn),
    .step       (step),
    .dir        (dir),
    .enable_in  (enable_in),
    .analog_cmp (analog_cmp),
    .cfg        (cfg),
    .gates      (gates),
    .faultn     (faultn),
    .phase_a    (phase_a),
    .phase_b    (phase_b),
    .phase_c    (phase_c)
  );

  tb_checker #(
    .OFF_TIME    (OFF_TIME),
    .BLANK_TIME  (BLANK_TIME),
    .MIN_ON_TIME (MIN_ON_TIME)
  ) checker0 (
    .clk        (clk),
    .resetn     (resetn),
    .step       (step),
    .dir        (dir),
    .enable_in  (enable_in),
    .analog_cmp (analog_cmp),
    .cfg        (cfg),
    .gates      (gates),
    .faultn     (faultn),
    .phase_a    (phase_a),
    .phase_b    (phase_b),
    .phase_c    (phase_c),
    .checks     (checks),
    .errors     (errors)
  );

  bind bridge_control bridge_chk chk0 (
    .clk       (clk),
    .resetn    (resetn),
    .high_ctrl (high_ctrl),
    .low_ctrl  (low_ctrl),
    .faultn    (faultn),
    .off_start (off_start),
    .timers    (timers)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(int n);
    for (int i = 0; i < n; i++) next_cycle();
  endtask

  task automatic apply_reset();
    resetn = 1'b0;
    wait_cycles(10);
    resetn = 1'b1;
  endtask

  // One step pulse, then wait for the counters to move
  task automatic pulse_step(logic up);
    phase_t old;
    int     n;
    old  = phase_a;
    dir  = up;
    step = 1'b1;
    next_cycle();
    step = 1'b0;
    n = 0;
    while (phase_a == old && n < 10) begin
      next_cycle();
      n++;
    end
    if (phase_a == old) begin
      timeouts++;
      $display("Timeout: phase counters did not move after a step pulse");
    end
    wait_cycles(1);
  endtask

  // Comparator pulse long enough for one trip
  task automatic trip_coils(logic [2:0] coils);
    analog_cmp = coils;
    next_cycle();
    analog_cmp = 3'b000;
  endtask

  task automatic wait_fault();
    int n;
    n = 0;
    while (faultn && n < 20) begin
      next_cycle();
      n++;
    end
    if (faultn) begin
      timeouts++;
      $display("Timeout: fault latch did not trip after an early comparator trip");
    end
  endtask

  initial begin
    timeouts   = 0;
    rnd        = $urandom(84140);
    resetn     = 1'b0;
    step       = 1'b0;
    dir        = 1'b0;
    enable_in  = 1'b0;
    analog_cmp = 3'b000;
    cfg        = '{fastdecay_threshold: 10'd25, invert_high: 1'b0, invert_low: 1'b0};
    apply_reset();
    enable_in = 1'b1;

    // Stepping and polarity, downwards across 0, a full turn up, then random
    for (int i = 0; i < 70; i++) pulse_step(1'b0);
    for (int i = 0; i < 200; i++) pulse_step(1'b1);
    for (int i = 0; i < 300; i++) begin
      rnd = $urandom();
      pulse_step(rnd[0]);
    end

    // Chopping on each coil alone, then all together
    for (int i = 0; i < 3; i++) begin
      trip_coils(3'b001 << i);
      wait_cycles(OFF_TIME + MIN_ON_TIME + 4);
      pulse_step(1'b1);
    end
    trip_coils(3'b111);
    wait_cycles(OFF_TIME + MIN_ON_TIME + 4);

    // Enable and inversion combinations
    for (int e = 0; e < 2; e++) begin
      enable_in = e[0];
      for (int k = 0; k < 4; k++) begin
        cfg.invert_high = k[1];
        cfg.invert_low  = k[0];
        wait_cycles(4);
        if (e == 1) begin
          trip_coils(3'b010);
          wait_cycles(OFF_TIME + MIN_ON_TIME + 4);
        end
      end
    end
    cfg.invert_high = 1'b0;
    cfg.invert_low  = 1'b0;

    // Trip inside the minimum on window latches the fault
    apply_reset();
    wait_cycles(BLANK_TIME + 2);
    trip_coils(3'b010);
    wait_fault();
    wait_cycles(60);
    pulse_step(1'b1);
    apply_reset();
    wait_cycles(5);

    $display("Checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
hw/stepper_pkg.sv
hw/step_decode.sv
hw/chopper_timers.sv
hw/bridge_control.sv
hw/microstepper_top.sv
test/bridge_chk.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f list.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TB FAILED" sim.log && exit 1 \
  || { grep -q "TB PASSED" sim.log && exit 0 || exit 1; }
